//--- trace_pkg.sv
// Trace encoder shared definitions
// Field widths, packet format and subformat codes, and the packet
// lengths that follow from them.

package trace_pkg;

    // core-side field widths
    localparam int unsigned XLEN     = 32;
    localparam int unsigned PRIVLEN  = 3;
    localparam int unsigned CAUSELEN = 5;

    // branch map capacity and entry count width
    localparam int unsigned BMAP_LEN = 31;
    localparam int unsigned BCNT_LEN = 5;

    // widest packet is a full branch map with address
    localparam int unsigned PACKET_LEN   = 2 + BCNT_LEN + BMAP_LEN + XLEN;
    localparam int unsigned PACKET_LEN_W = 7;

    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'd0,
        F_BRANCH_DIFF = 2'd1,  // reserved, never produced
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } trace_format_t;

    typedef enum logic [1:0] {
        SF_START     = 2'd0,
        SF_EXCEPTION = 2'd1,
        SF_CONTEXT   = 2'd2,  // not supported
        SF_UNDEF     = 2'd3
    } trace_subformat_t;

    // fixed packet lengths
    localparam logic [PACKET_LEN_W-1:0] LEN_SYNC_START =
        PACKET_LEN_W'(2 + 2 + PRIVLEN + 1 + XLEN);
    localparam logic [PACKET_LEN_W-1:0] LEN_SYNC_EXC =
        PACKET_LEN_W'(2 + 2 + PRIVLEN + 1 + XLEN + CAUSELEN + 1);
    localparam logic [PACKET_LEN_W-1:0] LEN_ADDR_ONLY =
        PACKET_LEN_W'(2 + XLEN);

    // branch full length without the map bits
    localparam logic [PACKET_LEN_W-1:0] LEN_BRANCH_BASE =
        PACKET_LEN_W'(2 + BCNT_LEN + XLEN);

endpackage

//--- trace_ctrl.sv
// Trace encoder controller
// Two-state machine that picks the packet for each retired instruction
// and drives the branch map flush and the resync timer restart.

`timescale 1ns/1ps

module trace_ctrl import trace_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                trace_enable_i,
    input  logic                ivalid_i,
    input  logic                exception_i,
    input  logic                updiscon_i,
    input  logic                timer_expired_i,
    input  logic [BCNT_LEN-1:0] map_cnt_i,
    output logic                emit_o,
    output trace_format_t       format_o,
    output trace_subformat_t    subformat_o,
    output logic                map_flush_o,
    output logic                timer_restart_o
);

    typedef enum logic {
        S_IDLE,
        S_TRACE
    } state_t;

    state_t state_q, state_d;

    always_comb begin
        state_d         = state_q;
        emit_o          = 1'b0;
        format_o        = F_SYNC;
        subformat_o     = SF_START;
        map_flush_o     = 1'b0;
        timer_restart_o = 1'b0;

        if (!trace_enable_i) begin
            // leaving trace drops whatever the map holds
            state_d     = S_IDLE;
            map_flush_o = (state_q == S_TRACE);
        end else if (ivalid_i) begin
            if (state_q == S_IDLE) begin
                state_d         = S_TRACE;
                emit_o          = 1'b1;
                map_flush_o     = 1'b1;
                timer_restart_o = 1'b1;
            end else if (exception_i) begin
                emit_o          = 1'b1;
                subformat_o     = SF_EXCEPTION;
                map_flush_o     = 1'b1;
                timer_restart_o = 1'b1;
            end else if (map_cnt_i == BCNT_LEN'(BMAP_LEN)) begin
                // map view is full, current entry included
                emit_o      = 1'b1;
                format_o    = F_BRANCH_FULL;
                map_flush_o = 1'b1;
            end else if (timer_expired_i) begin
                emit_o          = 1'b1;
                map_flush_o     = 1'b1;
                timer_restart_o = 1'b1;
            end else if (updiscon_i) begin
                emit_o = 1'b1;
                if (map_cnt_i != '0) begin
                    format_o    = F_BRANCH_FULL;
                    map_flush_o = 1'b1;
                end else begin
                    format_o = F_ADDR_ONLY;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- resync_timer.sv
// Resync timer
// Counts retired instructions since the last sync packet and flags
// when the count has reached the resync period.

`timescale 1ns/1ps

module resync_timer #(
    parameter int unsigned RESYNC_PERIOD = 64
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic count_en_i,
    input  logic restart_i,
    output logic expired_o
);

    localparam int unsigned CNT_W = $clog2(RESYNC_PERIOD + 1);

    logic [CNT_W-1:0] cnt_q;

    // compare on the held count only
    assign expired_o = (cnt_q >= CNT_W'(RESYNC_PERIOD));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (restart_i) begin
            cnt_q <= '0;
        end else if (count_en_i && !expired_o) begin
            // saturate once expired
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

//--- branch_map.sv
// Branch map
// Shift register of conditional branch outcomes plus an entry count.
// The outputs show the next-state view, so a branch recorded in the
// current cycle is already visible to the packet logic.

`timescale 1ns/1ps

module branch_map import trace_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                record_i,
    input  logic                taken_i,
    input  logic                flush_i,
    output logic [BMAP_LEN-1:0] map_o,
    output logic [BCNT_LEN-1:0] cnt_o
);

    logic [BMAP_LEN-1:0] map_q;
    logic [BCNT_LEN-1:0] cnt_q;

    always_comb begin
        map_o = map_q;
        cnt_o = cnt_q;
        if (record_i) begin
            // newest outcome enters at bit 0, taken is 1
            map_o = {map_q[BMAP_LEN-2:0], taken_i};
            cnt_o = cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q <= '0;
            cnt_q <= '0;
        end else if (flush_i) begin
            // entry of this cycle is consumed by the packet
            map_q <= '0;
            cnt_q <= '0;
        end else begin
            map_q <= map_o;
            cnt_q <= cnt_o;
        end
    end

endmodule

//--- packet_emitter.sv
// Packet emitter
// Packs format, subformat and payload fields into one packet word
// with its bit length, and registers it together with a write strobe
// for the packet buffer. Branch-full packets carry the map in a
// bucketed width chosen from the entry count.

`timescale 1ns/1ps

module packet_emitter import trace_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    emit_i,
    input  trace_format_t           format_i,
    input  trace_subformat_t        subformat_i,
    input  logic [BMAP_LEN-1:0]     map_i,
    input  logic [BCNT_LEN-1:0]     map_cnt_i,
    input  logic [XLEN-1:0]         iaddr_i,
    input  logic                    is_branch_i,
    input  logic [PRIVLEN-1:0]      priv_i,
    input  logic [CAUSELEN-1:0]     cause_i,
    input  logic                    interrupt_i,
    output logic [PACKET_LEN-1:0]   packet_bits_o,
    output logic [PACKET_LEN_W-1:0] packet_len_o,
    output logic                    packet_valid_o
);

    // field offsets inside a packet
    localparam int unsigned PRIV_LSB   = 4;
    localparam int unsigned SYNC_ADDR  = PRIV_LSB + PRIVLEN + 1;
    localparam int unsigned CAUSE_LSB  = SYNC_ADDR + XLEN;
    localparam int unsigned BF_MAP_LSB = 2 + BCNT_LEN;

    logic [PACKET_LEN-1:0]   pkt_bits;
    logic [PACKET_LEN_W-1:0] pkt_len;

    always_comb begin
        pkt_bits      = '0;
        pkt_len       = '0;
        pkt_bits[1:0] = format_i;

        case (format_i)
            F_SYNC: begin
                pkt_bits[3:2]                = subformat_i;
                pkt_bits[PRIV_LSB +: PRIVLEN] = priv_i;
                pkt_bits[PRIV_LSB + PRIVLEN] = is_branch_i;
                pkt_bits[SYNC_ADDR +: XLEN]  = iaddr_i;
                if (subformat_i == SF_EXCEPTION) begin
                    pkt_bits[CAUSE_LSB +: CAUSELEN] = cause_i;
                    pkt_bits[CAUSE_LSB + CAUSELEN]  = interrupt_i;
                    pkt_len = LEN_SYNC_EXC;
                end else begin
                    pkt_len = LEN_SYNC_START;
                end
            end

            F_ADDR_ONLY: begin
                pkt_bits[2 +: XLEN] = iaddr_i;
                pkt_len             = LEN_ADDR_ONLY;
            end

            F_BRANCH_FULL: begin
                pkt_bits[2 +: BCNT_LEN] = map_cnt_i;
                // map width in buckets of 1, 9, 17, 25 and 31
                if (map_cnt_i == '0) begin
                    pkt_bits[BF_MAP_LSB]             = map_i[0];
                    pkt_bits[BF_MAP_LSB + 1 +: XLEN] = iaddr_i;
                    pkt_len = LEN_BRANCH_BASE + 7'd1;
                end else if (map_cnt_i <= 5'd8) begin
                    pkt_bits[BF_MAP_LSB +: 9]        = map_i[8:0];
                    pkt_bits[BF_MAP_LSB + 9 +: XLEN] = iaddr_i;
                    pkt_len = LEN_BRANCH_BASE + 7'd9;
                end else if (map_cnt_i <= 5'd16) begin
                    pkt_bits[BF_MAP_LSB +: 17]        = map_i[16:0];
                    pkt_bits[BF_MAP_LSB + 17 +: XLEN] = iaddr_i;
                    pkt_len = LEN_BRANCH_BASE + 7'd17;
                end else if (map_cnt_i <= 5'd24) begin
                    pkt_bits[BF_MAP_LSB +: 25]        = map_i[24:0];
                    pkt_bits[BF_MAP_LSB + 25 +: XLEN] = iaddr_i;
                    pkt_len = LEN_BRANCH_BASE + 7'd25;
                end else begin
                    pkt_bits[BF_MAP_LSB +: BMAP_LEN]        = map_i;
                    pkt_bits[BF_MAP_LSB + BMAP_LEN +: XLEN] = iaddr_i;
                    pkt_len = LEN_BRANCH_BASE + PACKET_LEN_W'(BMAP_LEN);
                end
            end

            // differential branch format is reserved
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= emit_i;
        end
    end

    // payload only loads on an emitted packet
    always_ff @(posedge clk_i) begin
        if (emit_i) begin
            packet_bits_o <= pkt_bits;
            packet_len_o  <= pkt_len;
        end
    end

endmodule

//--- packet_fifo.sv
// Packet buffer
// Circular first-word-fall-through buffer for trace packets with a
// valid/grant read port. A write into a full buffer is dropped and
// sets a sticky overflow flag.

`timescale 1ns/1ps

module packet_fifo import trace_pkg::*; #(
    parameter int unsigned BUFFER_DEPTH = 8
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    wr_valid_i,
    input  logic [PACKET_LEN-1:0]   wr_bits_i,
    input  logic [PACKET_LEN_W-1:0] wr_len_i,
    output logic [PACKET_LEN-1:0]   rd_bits_o,
    output logic [PACKET_LEN_W-1:0] rd_len_o,
    output logic                    rd_valid_o,
    input  logic                    rd_grant_i,
    output logic                    overflow_o
);

    localparam int unsigned PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(BUFFER_DEPTH + 1);

    logic [PACKET_LEN-1:0]   mem_bits [BUFFER_DEPTH];
    logic [PACKET_LEN_W-1:0] mem_len  [BUFFER_DEPTH];
    logic [PTR_W-1:0]        wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0]        cnt_q;
    logic                    full, do_rd, do_wr;

    // pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full       = (cnt_q == CNT_W'(BUFFER_DEPTH));
    assign rd_valid_o = (cnt_q != '0);
    assign rd_bits_o  = mem_bits[rd_ptr_q];
    assign rd_len_o   = mem_len[rd_ptr_q];
    assign do_rd      = rd_valid_o & rd_grant_i;
    // a read in the same cycle frees a slot
    assign do_wr      = wr_valid_i & (~full | do_rd);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            cnt_q      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_rd) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            if (do_wr && !do_rd) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (do_rd && !do_wr) begin
                cnt_q <= cnt_q - 1'b1;
            end
            // sticky until reset
            if (wr_valid_i && !do_wr) begin
                overflow_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem_bits[wr_ptr_q] <= wr_bits_i;
            mem_len[wr_ptr_q]  <= wr_len_i;
        end
    end

endmodule

//--- trace_encoder_top.sv
// RISC-V instruction trace encoder
// Watches the retirement strobe, decides on sync, address-only and
// branch-full packets, and queues them for an off-chip decoder behind
// a valid/grant port.

`timescale 1ns/1ps

module trace_encoder_top import trace_pkg::*; #(
    parameter int unsigned RESYNC_PERIOD = 64,
    parameter int unsigned BUFFER_DEPTH  = 8
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    trace_enable_i,
    input  logic                    ivalid_i,
    input  logic [XLEN-1:0]         iaddr_i,
    input  logic                    is_branch_i,
    input  logic                    branch_taken_i,
    input  logic                    updiscon_i,
    input  logic                    exception_i,
    input  logic                    interrupt_i,
    input  logic [CAUSELEN-1:0]     cause_i,
    input  logic [PRIVLEN-1:0]      priv_i,
    input  logic                    grant_i,
    output logic [PACKET_LEN-1:0]   packet_bits_o,
    output logic [PACKET_LEN_W-1:0] packet_len_o,
    output logic                    valid_o,
    output logic                    overflow_o
);

    logic                    strobe_en;
    logic                    emit;
    trace_format_t           format;
    trace_subformat_t        subformat;
    logic                    map_flush;
    logic                    timer_restart;
    logic                    timer_expired;
    logic [BMAP_LEN-1:0]     map;
    logic [BCNT_LEN-1:0]     map_cnt;
    logic [PACKET_LEN-1:0]   pkt_bits;
    logic [PACKET_LEN_W-1:0] pkt_len;
    logic                    pkt_valid;

    // strobes only count while tracing is enabled
    assign strobe_en = ivalid_i & trace_enable_i;

    trace_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .trace_enable_i  (trace_enable_i),
        .ivalid_i        (ivalid_i),
        .exception_i     (exception_i),
        .updiscon_i      (updiscon_i),
        .timer_expired_i (timer_expired),
        .map_cnt_i       (map_cnt),
        .emit_o          (emit),
        .format_o        (format),
        .subformat_o     (subformat),
        .map_flush_o     (map_flush),
        .timer_restart_o (timer_restart)
    );

    resync_timer #(
        .RESYNC_PERIOD (RESYNC_PERIOD)
    ) u_timer (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .count_en_i (strobe_en),
        .restart_i  (timer_restart),
        .expired_o  (timer_expired)
    );

    branch_map u_map (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .record_i (strobe_en & is_branch_i),
        .taken_i  (branch_taken_i),
        .flush_i  (map_flush),
        .map_o    (map),
        .cnt_o    (map_cnt)
    );

    packet_emitter u_emitter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .emit_i         (emit),
        .format_i       (format),
        .subformat_i    (subformat),
        .map_i          (map),
        .map_cnt_i      (map_cnt),
        .iaddr_i        (iaddr_i),
        .is_branch_i    (is_branch_i),
        .priv_i         (priv_i),
        .cause_i        (cause_i),
        .interrupt_i    (interrupt_i),
        .packet_bits_o  (pkt_bits),
        .packet_len_o   (pkt_len),
        .packet_valid_o (pkt_valid)
    );

    packet_fifo #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_fifo (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .wr_valid_i (pkt_valid),
        .wr_bits_i  (pkt_bits),
        .wr_len_i   (pkt_len),
        .rd_bits_o  (packet_bits_o),
        .rd_len_o   (packet_len_o),
        .rd_valid_o (valid_o),
        .rd_grant_i (grant_i),
        .overflow_o (overflow_o)
    );

endmodule

//--- trace_checker.sv
// Trace packet checker
// Keeps the expected packets in order, compares each transfer on the
// output port and prints the closing error count.

`timescale 1ns/1ps

module trace_checker import trace_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    valid_i,
    input  logic                    grant_i,
    input  logic [PACKET_LEN-1:0]   bits_i,
    input  logic [PACKET_LEN_W-1:0] len_i,
    input  logic                    exp_push_i,
    input  logic [PACKET_LEN-1:0]   exp_bits_i,
    input  logic [PACKET_LEN_W-1:0] exp_len_i,
    input  int                      ext_errors_i,
    input  logic                    done_i,
    output int                      pending_o,
    output int                      errors_o
);

    logic [PACKET_LEN-1:0]   exp_bits_q[$];
    logic [PACKET_LEN_W-1:0] exp_len_q[$];
    int   cmp_errors = 0;
    int   transfers = 0;
    logic reported = 1'b0;

    assign pending_o = exp_bits_q.size();
    assign errors_o  = cmp_errors + ext_errors_i;

    always @(posedge clk_i) begin
        if (exp_push_i) begin
            exp_bits_q.push_back(exp_bits_i);
            exp_len_q.push_back(exp_len_i);
        end
        if (rst_ni && valid_i && grant_i) begin
            transfers++;
            if (exp_bits_q.size() == 0) begin
                $display("packet transferred at %0t while no packet was expected", $time);
                cmp_errors++;
            end else begin
                if (bits_i !== exp_bits_q[0]) begin
                    $display("ERROR %0t packet_bits_o expected %h got %h",
                             $time, exp_bits_q[0], bits_i);
                    cmp_errors++;
                end
                if (len_i !== exp_len_q[0]) begin
                    $display("ERROR %0t packet_len_o expected %0d got %0d",
                             $time, exp_len_q[0], len_i);
                    cmp_errors++;
                end
                void'(exp_bits_q.pop_front());
                void'(exp_len_q.pop_front());
            end
        end
        if (done_i && !reported) begin
            reported = 1'b1;
            if (exp_bits_q.size() != 0) begin
                $display("%0d expected packets never arrived", exp_bits_q.size());
                cmp_errors++;
            end
            $display("checker: %0d transfers, %0d compare errors, %0d other errors, %s",
                     transfers, cmp_errors, ext_errors_i,
                     (cmp_errors + ext_errors_i == 0) ? "PASS" : "FAIL");
        end
    end

endmodule

//--- trace_encoder_assert.sv
// Trace encoder output port assertions
// Reset, handshake stability, sticky overflow and legal lengths.

`timescale 1ns/1ps

module trace_assert import trace_pkg::*; (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    valid_o,
    input logic                    grant_i,
    input logic                    overflow_o,
    input logic [PACKET_LEN-1:0]   packet_bits_o,
    input logic [PACKET_LEN_W-1:0] packet_len_o
);

    a_reset_valid: assert property (@(posedge clk_i) !rst_ni |-> !valid_o)
        else $error("valid_o high during reset");

    a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !grant_i |=> $stable(packet_bits_o) && $stable(packet_len_o))
        else $error("packet changed while waiting for grant");

    a_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        overflow_o |=> overflow_o)
        else $error("overflow_o fell");

    a_len: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o |-> packet_len_o inside {7'd34, 7'd40, 7'd46, 7'd48, 7'd56, 7'd64, 7'd70})
        else $error("illegal packet length %0d", packet_len_o);

endmodule

bind trace_encoder_top trace_assert u_assert (
    .clk_i(clk_i), .rst_ni(rst_ni), .valid_o(valid_o), .grant_i(grant_i),
    .overflow_o(overflow_o), .packet_bits_o(packet_bits_o), .packet_len_o(packet_len_o)
);

//--- tb_trace_encoder.sv
// Testbench for the trace encoder
// Drives retirement strobes through start, branch runs, exceptions,
// resync, back-pressure and disable phases. A reference model predicts
// each packet and hands it to the checker.

`timescale 1ns/1ps

module tb_trace_encoder import trace_pkg::*;;

    localparam int unsigned RESYNC_PERIOD = 16;
    localparam int unsigned BUFFER_DEPTH  = 4;
    // about 150 strobes plus reset, gaps and drain waits, with margin
    localparam int unsigned STIM_CYCLES   = 400;
    localparam int unsigned TIMEOUT       = 3 * STIM_CYCLES + 200;

    logic clk_i = 1'b0;
    logic rst_ni, trace_enable_i, ivalid_i, is_branch_i, branch_taken_i;
    logic updiscon_i, exception_i, interrupt_i, grant_i, valid_o, overflow_o;
    logic [XLEN-1:0]         iaddr_i;
    logic [CAUSELEN-1:0]     cause_i;
    logic [PRIVLEN-1:0]      priv_i;
    logic [PACKET_LEN-1:0]   packet_bits_o, exp_bits;
    logic [PACKET_LEN_W-1:0] packet_len_o, exp_len;
    logic exp_push, done, rand_grant, hold_grant;
    int   pending, errors, tb_errors, expect_left, cycle_cnt;
    integer seed = 32'hdfcb;

    // branch run lengths covering each map bucket
    int   run_lens[4] = '{1, 9, 17, 25};

    // reference model state
    logic [BMAP_LEN-1:0] m_map;
    int   m_cnt, m_since;
    logic m_idle;

    trace_encoder_top #(.RESYNC_PERIOD(RESYNC_PERIOD), .BUFFER_DEPTH(BUFFER_DEPTH)) UUT (.*);

    trace_checker u_checker (
        .clk_i(clk_i), .rst_ni(rst_ni), .valid_i(valid_o), .grant_i(grant_i),
        .bits_i(packet_bits_o), .len_i(packet_len_o), .exp_push_i(exp_push),
        .exp_bits_i(exp_bits), .exp_len_i(exp_len), .ext_errors_i(tb_errors),
        .done_i(done), .pending_o(pending), .errors_o(errors)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout after %0d cycles, the DUT stopped delivering packets", cycle_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // expected packet for one strobe while enabled, first match wins
    function automatic logic trace_model_packet(input logic [XLEN-1:0] addr,
            input logic br, tk, upd, exc, intr, input logic [CAUSELEN-1:0] cause,
            input logic [PRIVLEN-1:0] priv, output logic [PACKET_LEN-1:0] bits,
            output logic [PACKET_LEN_W-1:0] len);
        logic [BMAP_LEN-1:0] vmap;
        int   vcnt, w;
        logic emit, sync, bfull;
        vmap  = br ? {m_map[BMAP_LEN-2:0], tk} : m_map;
        vcnt  = m_cnt + int'(br);
        sync  = m_idle || exc || (vcnt != 31 && m_since >= RESYNC_PERIOD);
        bfull = !sync && (vcnt == 31 || (upd && vcnt != 0));
        emit  = sync || bfull || upd;
        bits  = '0;
        len   = '0;
        if (sync) begin
            bits[1:0] = 2'd3;
            bits[3:2] = (exc && !m_idle) ? 2'd1 : 2'd0;
            bits[6:4] = priv;
            bits[7]   = br;
            bits[39:8] = addr;
            len = 40;
            if (exc && !m_idle) begin
                bits[44:40] = cause;
                bits[45]    = intr;
                len = 46;
            end
        end else if (bfull) begin
            w = (vcnt <= 8) ? 9 : (vcnt <= 16) ? 17 : (vcnt <= 24) ? 25 : 31;
            bits[6:2] = vcnt[4:0];
            for (int i = 0; i < w; i++) bits[7 + i] = vmap[i];
            for (int i = 0; i < 32; i++) bits[7 + w + i] = addr[i];
            len = PACKET_LEN_W'(39 + w);
        end else if (upd) begin
            bits[1:0]  = 2'd2;
            bits[33:2] = addr;
            len = 34;
        end
        m_idle  = 1'b0;
        m_since = sync ? 0 : m_since + 1;
        m_map   = (sync || bfull) ? '0 : vmap;
        m_cnt   = (sync || bfull) ? 0 : vcnt;
        return emit;
    endfunction

    task automatic drive_grant();
        grant_i = rand_grant ? 1'($random(seed)) : hold_grant;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            drive_grant();
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic retire(input logic br, tk, upd, exc, intr, input logic [4:0] cause);
        logic [PACKET_LEN-1:0]   b;
        logic [PACKET_LEN_W-1:0] l;
        logic e;
        iaddr_i = $random(seed) & 32'hffff_fffc;
        priv_i  = 3'($random(seed));
        {is_branch_i, branch_taken_i, updiscon_i, exception_i, interrupt_i} =
            {br, tk, upd, exc, intr};
        cause_i  = cause;
        ivalid_i = 1'b1;
        e = trace_enable_i && trace_model_packet(iaddr_i, br, tk, upd, exc, intr,
                                                 cause, priv_i, b, l);
        if (e && expect_left > 0) begin
            expect_left--;
            exp_push = 1'b1;
            exp_bits = b;
            exp_len  = l;
        end
        idle(1);
        {ivalid_i, exp_push, is_branch_i, updiscon_i, exception_i, interrupt_i} = '0;
    endtask

    // run of random branches closed by an uninferable jump
    task automatic branch_run(input int n);
        repeat (n) retire(1'b1, 1'($random(seed)), 1'b0, 1'b0, 1'b0, 5'd0);
        retire(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 5'd0);
    endtask

    task automatic wait_drain();
        while (pending != 0 || valid_o) idle(1);
    endtask

    // strobe into an empty buffer and expect valid_o exactly two cycles later
    task automatic retire_timed(input logic br, upd);
        logic early;
        wait_drain();
        retire(br, 1'b0, upd, 1'b0, 1'b0, 5'd0);
        early = valid_o;
        idle(1);
        if (early || !valid_o) begin
            $display("valid_o did not rise exactly two cycles after the strobe at %0t", $time);
            tb_errors++;
        end
    endtask

    initial begin
        {rst_ni, trace_enable_i, ivalid_i, is_branch_i, branch_taken_i} = '0;
        {updiscon_i, exception_i, interrupt_i, exp_push, done, rand_grant} = '0;
        {iaddr_i, cause_i, priv_i, exp_bits, exp_len} = '0;
        {grant_i, hold_grant} = 2'b11;
        {m_map, m_cnt, m_since, m_idle} = '0;
        m_idle = 1'b1;
        {tb_errors, cycle_cnt} = '0;
        expect_left = 1 << 30;
        repeat (4) @(posedge clk_i);
        #2 rst_ni = 1'b1;
        idle(2);

        trace_enable_i = 1'b1;
        retire_timed(1'b1, 1'b0);
        retire_timed(1'b0, 1'b1);
        retire_timed(1'b0, 1'b1);
        branch_run(31);
        foreach (run_lens[i]) branch_run(run_lens[i]);

        branch_run(0);
        repeat (5) retire(1'b1, 1'($random(seed)), 1'b0, 1'b0, 1'b0, 5'd0);
        retire(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 5'd2);
        repeat (3) retire(1'b1, 1'($random(seed)), 1'b0, 1'b0, 1'b0, 5'd0);
        retire(1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 5'd7);
        repeat (3) retire(1'b1, 1'($random(seed)), 1'b0, 1'b0, 1'b0, 5'd0);
        repeat (18) retire(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0);
        wait_drain();

        rand_grant = 1'b1;
        branch_run(6);
        repeat (4) retire(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 5'd0);
        branch_run(3);
        rand_grant = 1'b0;
        wait_drain();
        hold_grant  = 1'b0;
        expect_left = BUFFER_DEPTH;
        repeat (6) retire(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 5'd0);
        idle(2);
        if (!overflow_o) begin
            $display("overflow_o stayed low after packets were dropped at %0t", $time);
            tb_errors++;
        end
        hold_grant  = 1'b1;
        expect_left = 1 << 30;
        wait_drain();

        trace_enable_i = 1'b0;
        m_idle = 1'b1;
        m_map  = '0;
        m_cnt  = 0;
        repeat (3) retire(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 5'd0);
        trace_enable_i = 1'b1;
        retire(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0);
        wait_drain();

        done = 1'b1;
        idle(2);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- flist.f
trace_pkg.sv
trace_ctrl.sv
resync_timer.sv
branch_map.sv
packet_emitter.sv
packet_fifo.sv
trace_encoder_top.sv
trace_checker.sv
trace_encoder_assert.sv
tb_trace_encoder.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the trace encoder testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_trace_encoder -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
exit 0
